//--- design/isa_pkg.sv
package isa_pkg;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // Register forms only, SUB sets bit 30
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR
  } alu_cmd_t;

  // Source of the second ALU operand
  typedef enum logic {
    REG,
    IMM
  } op_type_t;

endpackage

//--- design/core_pkg.sv
package core_pkg;

  localparam int DISPATCH_WIDTH = 2;
  localparam int ARCH_REGS      = 32;
  localparam int PHYS_REGS      = 64;
  localparam int ROB_DEPTH      = 16;

  typedef logic [31:0]                  word_t;
  typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;
  typedef logic [$clog2(PHYS_REGS)-1:0] phys_reg_t;
  typedef logic [$clog2(ROB_DEPTH)-1:0] rob_ptr_t;
  // Free list occupancy, zero up to PHYS_REGS
  typedef logic [$clog2(PHYS_REGS):0]   free_count_t;

  localparam word_t RESET_PC = 32'h8000_0000;

  typedef struct packed {
    logic              valid;
    word_t             pc;
    arch_reg_t         rs1;
    arch_reg_t         rs2;
    arch_reg_t         rd;
    isa_pkg::alu_cmd_t alu_cmd;
    isa_pkg::op_type_t op2_type;
    word_t             imm;
  } decoded_t;

  typedef struct packed {
    logic              valid;
    word_t             pc;
    arch_reg_t         arch_rd;
    phys_reg_t         phys_rs1;
    phys_reg_t         phys_rs2;
    phys_reg_t         phys_rd;
    phys_reg_t         old_phys_rd;
    isa_pkg::alu_cmd_t alu_cmd;
    isa_pkg::op_type_t op2_type;
    word_t             imm;
  } renamed_t;

  typedef struct packed {
    logic      valid;
    rob_ptr_t  rob_addr;
    phys_reg_t phys_rd;
    word_t     data;
  } wb_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    arch_reg_t arch_rd;
    word_t     data;
    phys_reg_t old_phys_rd;
  } commit_t;

endpackage

//--- design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                                              clk,
  input  logic                                              rst,
  input  core_pkg::word_t    [core_pkg::DISPATCH_WIDTH-1:0] instruction,
  input  logic               [core_pkg::DISPATCH_WIDTH-1:0] instr_valid,
  input  logic                                              rename_stall,
  output core_pkg::word_t                                   pc,
  output core_pkg::decoded_t [core_pkg::DISPATCH_WIDTH-1:0] decoded
);
  import core_pkg::*;
  import isa_pkg::*;

  word_t [DISPATCH_WIDTH-1:0] fetch_word;
  word_t [DISPATCH_WIDTH-1:0] fetch_pc;
  logic  [DISPATCH_WIDTH-1:0] fetch_valid;

  function automatic decoded_t decode_word(input word_t instr, input word_t instr_pc,
                                           input logic lane_valid);
    decoded_t   d;
    logic       supported;
    logic [2:0] f3;
    logic [6:0] f7;
    d          = '0;
    supported  = 1'b1;
    f3         = instr[14:12];
    f7         = instr[31:25];
    d.pc       = instr_pc;
    d.rs1      = instr[19:15];
    d.rs2      = instr[24:20];
    d.rd       = instr[11:7];
    d.imm      = {{20{instr[31]}}, instr[31:20]};
    d.alu_cmd  = ADD;
    d.op2_type = IMM;
    case (instr[6:0])
      OPC_OP_IMM: begin
        case (f3)
          F3_ADD:  d.alu_cmd = ADD;
          F3_XOR:  d.alu_cmd = XOR;
          F3_OR:   d.alu_cmd = OR;
          F3_AND:  d.alu_cmd = AND;
          default: supported = 1'b0;
        endcase
      end
      OPC_OP: begin
        d.op2_type = REG;
        case ({f7, f3})
          {F7_BASE, F3_ADD}: d.alu_cmd = ADD;
          {F7_SUB, F3_ADD}:  d.alu_cmd = SUB;
          {F7_BASE, F3_XOR}: d.alu_cmd = XOR;
          {F7_BASE, F3_OR}:  d.alu_cmd = OR;
          {F7_BASE, F3_AND}: d.alu_cmd = AND;
          default:           supported = 1'b0;
        endcase
      end
      default: supported = 1'b0;
    endcase
    // Anything we can't execute turns into an x0 write and drops out
    if (!supported) begin
      d.rd = '0;
    end
    d.valid = lane_valid && (d.rd != '0);
    return d;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      pc          <= RESET_PC;
      fetch_valid <= '0;
    end else if (!rename_stall) begin
      if (&instr_valid) begin
        pc <= pc + 32'd8;
      end else if (|instr_valid) begin
        pc <= pc + 32'd4;
      end
      // A lone word in lane 1 is the one at pc, shift it down
      fetch_valid   <= {&instr_valid, |instr_valid};
      fetch_word[0] <= instr_valid[0] ? instruction[0] : instruction[1];
      fetch_word[1] <= instruction[1];
      fetch_pc[0]   <= pc;
      fetch_pc[1]   <= pc + 32'd4;
    end
  end

  always_comb begin
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      decoded[i] = decode_word(fetch_word[i], fetch_pc[i], fetch_valid[i]);
    end
  end

endmodule

//--- design/free_list.sv
`timescale 1ns/1ps

module free_list (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic                [core_pkg::DISPATCH_WIDTH-1:0] pop,
  output core_pkg::phys_reg_t [core_pkg::DISPATCH_WIDTH-1:0] pop_reg,
  input  core_pkg::commit_t   [core_pkg::DISPATCH_WIDTH-1:0] commit,
  output core_pkg::free_count_t                              free_count
);
  import core_pkg::*;

  typedef logic [$clog2(PHYS_REGS)-1:0] ptr_t;

  phys_reg_t                 entries [PHYS_REGS];
  ptr_t                      head;
  ptr_t                      tail;
  logic [DISPATCH_WIDTH-1:0] push;
  logic [1:0]                n_pop;
  logic [1:0]                n_push;

  always_comb begin
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      push[i] = commit[i].valid;
    end
  end

  assign n_pop  = 2'($countones(pop));
  assign n_push = 2'($countones(push));

  // Lane 1 takes the head when lane 0 pops nothing
  assign pop_reg[0] = entries[head];
  assign pop_reg[1] = entries[head + ptr_t'(pop[0])];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < PHYS_REGS; i++) begin
        entries[i] <= phys_reg_t'(ARCH_REGS + i);
      end
      head       <= '0;
      tail       <= ptr_t'(PHYS_REGS - ARCH_REGS);
      free_count <= free_count_t'(PHYS_REGS - ARCH_REGS);
    end else begin
      // Commit lanes are contiguous from lane 0
      for (int i = 0; i < DISPATCH_WIDTH; i++) begin
        if (push[i]) begin
          entries[tail + ptr_t'(i)] <= commit[i].old_phys_rd;
        end
      end
      head       <= head + n_pop;
      tail       <= tail + n_push;
      free_count <= free_count - n_pop + n_push;
    end
  end

  assert property (@(posedge clk) disable iff (rst) n_pop <= free_count)
    else $error("free list popped past its count");

endmodule

//--- design/rename_stage.sv
`timescale 1ns/1ps

module rename_stage (
  input  logic                                               clk,
  input  logic                                               rst,
  input  core_pkg::decoded_t  [core_pkg::DISPATCH_WIDTH-1:0] decoded,
  input  logic                                               issue_stall,
  input  logic                                               rob_full,
  input  core_pkg::phys_reg_t [core_pkg::DISPATCH_WIDTH-1:0] pop_reg,
  input  core_pkg::free_count_t                              free_count,
  output logic                [core_pkg::DISPATCH_WIDTH-1:0] pop,
  output logic                                               rename_stall,
  output core_pkg::renamed_t  [core_pkg::DISPATCH_WIDTH-1:0] renamed
);
  import core_pkg::*;

  phys_reg_t                     map_table [ARCH_REGS];
  renamed_t [DISPATCH_WIDTH-1:0] ren_next;

  assign rename_stall = issue_stall || rob_full || (free_count < 2);

  always_comb begin
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      pop[i]                  = decoded[i].valid && !rename_stall;
      ren_next[i].valid       = decoded[i].valid;
      ren_next[i].pc          = decoded[i].pc;
      ren_next[i].arch_rd     = decoded[i].rd;
      ren_next[i].phys_rs1    = map_table[decoded[i].rs1];
      ren_next[i].phys_rs2    = map_table[decoded[i].rs2];
      ren_next[i].phys_rd     = pop_reg[i];
      ren_next[i].old_phys_rd = map_table[decoded[i].rd];
      ren_next[i].alu_cmd     = decoded[i].alu_cmd;
      ren_next[i].op2_type    = decoded[i].op2_type;
      ren_next[i].imm         = decoded[i].imm;
    end
    // Lane 1 sees the mapping lane 0 creates this cycle
    if (decoded[0].valid) begin
      if (decoded[1].rs1 == decoded[0].rd) begin
        ren_next[1].phys_rs1 = pop_reg[0];
      end
      if (decoded[1].rs2 == decoded[0].rd) begin
        ren_next[1].phys_rs2 = pop_reg[0];
      end
      if (decoded[1].rd == decoded[0].rd) begin
        ren_next[1].old_phys_rd = pop_reg[0];
      end
    end
  end

  // Lane 1 is written last so it wins on a shared rd
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int a = 0; a < ARCH_REGS; a++) begin
        map_table[a] <= phys_reg_t'(a);
      end
    end else begin
      for (int i = 0; i < DISPATCH_WIDTH; i++) begin
        if (pop[i]) begin
          map_table[decoded[i].rd] <= pop_reg[i];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DISPATCH_WIDTH; i++) begin
        renamed[i].valid <= 1'b0;
      end
    end else if (!issue_stall) begin
      renamed <= ren_next;
      // Bubble behind the pair execute just took
      if (rename_stall) begin
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
          renamed[i].valid <= 1'b0;
        end
      end
    end
  end

endmodule

//--- design/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
  input  logic                                              clk,
  input  logic                                              rst,
  input  core_pkg::renamed_t [core_pkg::DISPATCH_WIDTH-1:0] renamed,
  input  logic                                              accept,
  input  core_pkg::wb_t      [core_pkg::DISPATCH_WIDTH-1:0] wb,
  output core_pkg::rob_ptr_t [core_pkg::DISPATCH_WIDTH-1:0] alloc_addr,
  output logic                                              rob_full,
  output core_pkg::commit_t  [core_pkg::DISPATCH_WIDTH-1:0] commit
);
  import core_pkg::*;

  word_t     pc_q      [ROB_DEPTH];
  arch_reg_t arch_rd_q [ROB_DEPTH];
  phys_reg_t old_rd_q  [ROB_DEPTH];
  word_t     data_q    [ROB_DEPTH];
  logic      done_q    [ROB_DEPTH];

  rob_ptr_t                   head;
  rob_ptr_t                   tail;
  logic [$clog2(ROB_DEPTH):0] count;
  logic [DISPATCH_WIDTH-1:0]  lane_valid;
  logic [DISPATCH_WIDTH-1:0]  alloc_en;
  logic [DISPATCH_WIDTH-1:0]  commit_en;
  logic [1:0]                 n_pending;
  logic [1:0]                 n_alloc;
  logic [1:0]                 n_commit;

  always_comb begin
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      lane_valid[i] = renamed[i].valid;
      alloc_en[i]   = accept && renamed[i].valid;
    end
  end

  assign n_pending = 2'($countones(lane_valid));
  assign n_alloc   = 2'($countones(alloc_en));
  assign n_commit  = 2'($countones(commit_en));

  assign alloc_addr[0] = tail;
  assign alloc_addr[1] = tail + rob_ptr_t'(lane_valid[0]);

  // The pair waiting in the rename register has its entries reserved
  assign rob_full = (count + n_pending) > (ROB_DEPTH - 2);

  always_comb begin
    rob_ptr_t ptr;
    logic     in_order;
    in_order = 1'b1;
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      ptr                   = head + rob_ptr_t'(i);
      commit_en[i]          = in_order && (count > i) && done_q[ptr];
      in_order              = commit_en[i];
      commit[i].valid       = commit_en[i];
      commit[i].pc          = pc_q[ptr];
      commit[i].arch_rd     = arch_rd_q[ptr];
      commit[i].data        = data_q[ptr];
      commit[i].old_phys_rd = old_rd_q[ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head  <= head + n_commit;
      tail  <= tail + n_alloc;
      count <= count + n_alloc - n_commit;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      if (alloc_en[i]) begin
        pc_q[alloc_addr[i]]      <= renamed[i].pc;
        arch_rd_q[alloc_addr[i]] <= renamed[i].arch_rd;
        old_rd_q[alloc_addr[i]]  <= renamed[i].old_phys_rd;
        done_q[alloc_addr[i]]    <= 1'b0;
      end
      if (wb[i].valid) begin
        data_q[wb[i].rob_addr] <= wb[i].data;
        done_q[wb[i].rob_addr] <= 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) count + n_alloc <= ROB_DEPTH)
    else $error("ROB overflow");

  for (genvar i = 0; i < DISPATCH_WIDTH; i++) begin : g_wb_check
    assert property (@(posedge clk) disable iff (rst)
      wb[i].valid |-> rob_ptr_t'(wb[i].rob_addr - head) < count)
      else $error("writeback to an unallocated ROB entry");
  end

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                                              clk,
  input  logic                                              rst,
  input  core_pkg::renamed_t [core_pkg::DISPATCH_WIDTH-1:0] renamed,
  input  core_pkg::rob_ptr_t [core_pkg::DISPATCH_WIDTH-1:0] alloc_addr,
  output logic                                              accept,
  output logic                                              issue_stall,
  output core_pkg::wb_t      [core_pkg::DISPATCH_WIDTH-1:0] wb
);
  import core_pkg::*;
  import isa_pkg::*;

  renamed_t  [DISPATCH_WIDTH-1:0] iss;
  rob_ptr_t  [DISPATCH_WIDTH-1:0] iss_rob;
  logic      [DISPATCH_WIDTH-1:0] pending;
  logic      [DISPATCH_WIDTH-1:0] fire;
  logic      [DISPATCH_WIDTH-1:0] lane_valid;

  logic      [PHYS_REGS-1:0]      ready;
  word_t                          prf [PHYS_REGS];

  logic      [DISPATCH_WIDTH-1:0] ex_valid;
  alu_cmd_t  [DISPATCH_WIDTH-1:0] ex_cmd;
  word_t     [DISPATCH_WIDTH-1:0] ex_op1;
  word_t     [DISPATCH_WIDTH-1:0] ex_op2;
  phys_reg_t [DISPATCH_WIDTH-1:0] ex_rd;
  rob_ptr_t  [DISPATCH_WIDTH-1:0] ex_rob;

  function automatic word_t alu(input alu_cmd_t cmd, input word_t a, input word_t b);
    case (cmd)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      default: return '0;
    endcase
  endfunction

  assign issue_stall = |pending;
  assign accept      = |lane_valid && !issue_stall;

  // In order within the pair. A lane 1 source written by lane 0 is
  // still not ready here, since accept cleared its ready bit
  always_comb begin
    logic older_issued;
    older_issued = 1'b1;
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      lane_valid[i] = renamed[i].valid;
      fire[i]       = pending[i] && older_issued && ready[iss[i].phys_rs1] &&
                      (iss[i].op2_type == IMM || ready[iss[i].phys_rs2]);
      older_issued  = older_issued && (!pending[i] || fire[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else if (!issue_stall) begin
      pending <= lane_valid;
    end else begin
      pending <= pending & ~fire;
    end
  end

  always_ff @(posedge clk) begin
    if (!issue_stall) begin
      iss     <= renamed;
      iss_rob <= alloc_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int p = 0; p < PHYS_REGS; p++) begin
        ready[p] <= (p < ARCH_REGS);
        prf[p]   <= '0;
      end
    end else begin
      for (int i = 0; i < DISPATCH_WIDTH; i++) begin
        if (wb[i].valid) begin
          ready[wb[i].phys_rd] <= 1'b1;
          prf[wb[i].phys_rd]   <= wb[i].data;
        end
      end
      for (int i = 0; i < DISPATCH_WIDTH; i++) begin
        if (accept && lane_valid[i]) begin
          ready[renamed[i].phys_rd] <= 1'b0;
        end
      end
    end
  end

  // Operand read
  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= '0;
    end else begin
      ex_valid <= fire;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      ex_cmd[i] <= iss[i].alu_cmd;
      ex_op1[i] <= prf[iss[i].phys_rs1];
      ex_op2[i] <= (iss[i].op2_type == IMM) ? iss[i].imm : prf[iss[i].phys_rs2];
      ex_rd[i]  <= iss[i].phys_rd;
      ex_rob[i] <= iss_rob[i];
    end
  end

  always_comb begin
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      wb[i].valid    = ex_valid[i];
      wb[i].rob_addr = ex_rob[i];
      wb[i].phys_rd  = ex_rd[i];
      wb[i].data     = alu(ex_cmd[i], ex_op1[i], ex_op2[i]);
    end
  end

endmodule

//--- design/rename_core.sv
`timescale 1ns/1ps

module rename_core (
  input  logic                                              clk,
  input  logic                                              rst,
  output core_pkg::word_t                                   pc,
  input  core_pkg::word_t    [core_pkg::DISPATCH_WIDTH-1:0] instruction,
  input  logic               [core_pkg::DISPATCH_WIDTH-1:0] instr_valid,
  output core_pkg::commit_t  [core_pkg::DISPATCH_WIDTH-1:0] commit
);
  import core_pkg::*;

  decoded_t  [DISPATCH_WIDTH-1:0] decoded;
  renamed_t  [DISPATCH_WIDTH-1:0] renamed;
  wb_t       [DISPATCH_WIDTH-1:0] wb;
  phys_reg_t [DISPATCH_WIDTH-1:0] pop_reg;
  rob_ptr_t  [DISPATCH_WIDTH-1:0] alloc_addr;
  logic      [DISPATCH_WIDTH-1:0] pop;
  free_count_t                    free_count;
  logic                           rename_stall;
  logic                           issue_stall;
  logic                           rob_full;
  logic                           accept;

  decode_stage i_decode_stage (
    .clk, .rst,
    .instruction, .instr_valid,
    .rename_stall,
    .pc, .decoded
  );

  rename_stage i_rename_stage (
    .clk, .rst,
    .decoded,
    .issue_stall, .rob_full,
    .pop_reg, .free_count,
    .pop, .rename_stall,
    .renamed
  );

  free_list i_free_list (
    .clk, .rst,
    .pop, .pop_reg,
    .commit, .free_count
  );

  execute_stage i_execute_stage (
    .clk, .rst,
    .renamed, .alloc_addr,
    .accept, .issue_stall,
    .wb
  );

  reorder_buffer i_reorder_buffer (
    .clk, .rst,
    .renamed, .accept, .wb,
    .alloc_addr, .rob_full,
    .commit
  );

endmodule

//--- dv/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int PROG_LEN  = 120;
// Single-lane chain first, then dependent pairs, then random fetch
localparam int CHAIN_END = 16;
localparam int PAIR_END  = 40;

localparam logic [6:0] OPCODE_REG  = 7'b0110011;
localparam logic [6:0] OPCODE_IMM  = 7'b0010011;
localparam logic [6:0] OPCODE_LOAD = 7'b0000011;

typedef struct packed {
  word_t     pc;
  arch_reg_t rd;
  word_t     data;
  phys_reg_t old_rd;
} expect_t;

word_t   lfsr_state;
word_t   prog [PROG_LEN];
expect_t exp_q [$];

// Taps 32, 22, 2, 1
function automatic word_t lfsr_next(input word_t s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic word_t rand_bits(input int n);
  word_t r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    r = {r[30:0], lfsr_state[0]};
  end
  return r;
endfunction

function automatic word_t enc_imm(input logic [2:0] f3, input arch_reg_t rd,
                                  input arch_reg_t rs1, input logic [11:0] imm);
  return {imm, rs1, f3, rd, OPCODE_IMM};
endfunction

function automatic word_t enc_reg(input logic [6:0] f7, input logic [2:0] f3,
                                  input arch_reg_t rd, input arch_reg_t rs1,
                                  input arch_reg_t rs2);
  return {f7, rs2, rs1, f3, rd, OPCODE_REG};
endfunction

// One of the nine supported forms
function automatic word_t rand_instr(input arch_reg_t rd, input arch_reg_t rs1,
                                     input arch_reg_t rs2);
  logic [11:0] imm;
  word_t       sel;
  imm = 12'(rand_bits(12));
  sel = rand_bits(4) % 9;
  case (sel)
    0:       return enc_imm(3'b000, rd, rs1, imm);
    1:       return enc_imm(3'b100, rd, rs1, imm);
    2:       return enc_imm(3'b110, rd, rs1, imm);
    3:       return enc_imm(3'b111, rd, rs1, imm);
    4:       return enc_reg(7'b0000000, 3'b000, rd, rs1, rs2);
    5:       return enc_reg(7'b0100000, 3'b000, rd, rs1, rs2);
    6:       return enc_reg(7'b0000000, 3'b111, rd, rs1, rs2);
    7:       return enc_reg(7'b0000000, 3'b110, rd, rs1, rs2);
    default: return enc_reg(7'b0000000, 3'b100, rd, rs1, rs2);
  endcase
endfunction

// Load, shift, multiply and an odd SUB-style AND
function automatic word_t bad_instr(input arch_reg_t rd, input arch_reg_t rs1);
  case (rand_bits(2))
    0:       return {12'h010, rs1, 3'b010, rd, OPCODE_LOAD};
    1:       return enc_imm(3'b001, rd, rs1, 12'h003);
    2:       return enc_reg(7'b0000001, 3'b000, rd, rs1, 5'd2);
    default: return enc_reg(7'b0100000, 3'b111, rd, rs1, 5'd3);
  endcase
endfunction

task automatic build_program();
  arch_reg_t rd;
  arch_reg_t rs1;
  arch_reg_t rs2;
  arch_reg_t prev_rd;
  prev_rd = 5'd1;
  for (int i = 0; i < PROG_LEN; i++) begin
    rs1 = arch_reg_t'(rand_bits(3));
    rs2 = arch_reg_t'(rand_bits(3));
    rd  = arch_reg_t'(rand_bits(3));
    if (i < PAIR_END) begin
      if (rd == '0) begin
        rd = 5'd7;
      end
      // Odd index is lane 1 of a pair
      if (i < CHAIN_END || i % 2 == 1) begin
        rs1 = prev_rd;
      end
      if (i >= CHAIN_END && i % 2 == 1 && rand_bits(1) == 1) begin
        rs2 = prev_rd;
      end
      prog[i] = rand_instr(rd, rs1, rs2);
    end else if (rand_bits(4) == 0) begin
      prog[i] = bad_instr(rd, rs1);
    end else begin
      prog[i] = rand_instr(rd, rs1, rs2);
    end
    prev_rd = rd;
  end
endtask

function automatic logic ref_writes(input word_t instr);
  logic [6:0] opc;
  logic [6:0] f7;
  logic [2:0] f3;
  logic       f3_ok;
  logic       ok;
  opc   = instr[6:0];
  f7    = instr[31:25];
  f3    = instr[14:12];
  f3_ok = (f3 == 3'b000 || f3 == 3'b100 || f3 == 3'b110 || f3 == 3'b111);
  if (opc == OPCODE_IMM) begin
    ok = f3_ok;
  end else if (opc == OPCODE_REG) begin
    ok = (f7 == 7'b0000000 && f3_ok) || (f7 == 7'b0100000 && f3 == 3'b000);
  end else begin
    ok = 1'b0;
  end
  return ok && (instr[11:7] != '0);
endfunction

function automatic word_t ref_value(input word_t instr, input word_t a, input word_t b);
  word_t op2;
  op2 = (instr[6:0] == OPCODE_IMM) ? {{20{instr[31]}}, instr[31:20]} : b;
  if (instr[6:0] == OPCODE_REG && instr[30]) begin
    return a - op2;
  end
  case (instr[14:12])
    3'b100:  return a ^ op2;
    3'b110:  return a | op2;
    3'b111:  return a & op2;
    default: return a + op2;
  endcase
endfunction

// Sequential execution of the whole program
task automatic build_expected();
  word_t     regs [ARCH_REGS];
  phys_reg_t phys_of [ARCH_REGS];
  phys_reg_t free_q [$];
  expect_t   e;
  for (int r = 0; r < ARCH_REGS; r++) begin
    regs[r]    = '0;
    phys_of[r] = phys_reg_t'(r);
  end
  for (int p = ARCH_REGS; p < PHYS_REGS; p++) begin
    free_q.push_back(phys_reg_t'(p));
  end
  for (int i = 0; i < PROG_LEN; i++) begin
    if (ref_writes(prog[i])) begin
      e.pc    = RESET_PC + word_t'(4 * i);
      e.rd    = prog[i][11:7];
      e.data  = ref_value(prog[i], regs[prog[i][19:15]], regs[prog[i][24:20]]);
      e.old_rd = phys_of[e.rd];
      // Free registers go out in program order and come back at commit
      phys_of[e.rd] = free_q.pop_front();
      free_q.push_back(e.old_rd);
      regs[e.rd] = e.data;
      exp_q.push_back(e);
    end
  end
endtask

`endif

//--- dv/core_tb.sv
`timescale 1ns/1ps

module core_tb;
  import core_pkg::*;

  `include "tb_model.svh"

  localparam int CLK_PERIOD     = 4;
  localparam int RESET_CYCLES   = 8;
  localparam int DRIVE_DELAY    = 1;
  localparam int TIMEOUT_CYCLES = 40 * PROG_LEN + 200 + RESET_CYCLES;

  logic                         clk;
  logic                         rst;
  word_t                        pc;
  word_t   [DISPATCH_WIDTH-1:0] instruction;
  logic    [DISPATCH_WIDTH-1:0] instr_valid;
  commit_t [DISPATCH_WIDTH-1:0] commit;

  int value_errors;
  int order_errors;
  int commits_seen;
  int total_expected;

  rename_core i_rename_core (
    .clk,
    .rst,
    .pc,
    .instruction,
    .instr_valid,
    .commit
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_reg(input string name, input arch_reg_t expected,
                           input arch_reg_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected x%0d, actual x%0d", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_phys(input string name, input phys_reg_t expected,
                            input phys_reg_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected p%0d, actual p%0d", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic print_summary();
    $display("Errors: value %0d, order %0d, missing %0d; commits %0d of %0d",
             value_errors, order_errors, total_expected - commits_seen,
             commits_seen, total_expected);
  endtask

  // Mode 0 to 3 drives a pair, 4 and 7 lane 0 alone, 5 a lone lane 1 word, 6 nothing
  always @(posedge clk) begin : respond
    int    idx;
    word_t mode;
    #DRIVE_DELAY;
    idx  = int'((pc - RESET_PC) >> 2);
    mode = (idx < CHAIN_END) ? 32'd4 : (idx < PAIR_END) ? 32'd0 : rand_bits(3);
    instruction = '0;
    instr_valid = '0;
    if (idx < PROG_LEN) begin
      case (mode)
        0, 1, 2, 3: begin
          instruction[0] = prog[idx];
          instr_valid[0] = 1'b1;
          if (idx + 1 < PROG_LEN) begin
            instruction[1] = prog[idx + 1];
            instr_valid[1] = 1'b1;
          end
        end
        4, 7: begin
          instruction[0] = prog[idx];
          instr_valid[0] = 1'b1;
        end
        5: begin
          instruction[1] = prog[idx];
          instr_valid[1] = 1'b1;
        end
        default: ;
      endcase
    end
  end

  // Lane 0 is older, so it takes the queue head first
  always @(negedge clk) begin : compare
    expect_t e;
    if (!rst) begin
      for (int i = 0; i < DISPATCH_WIDTH; i++) begin
        if (commit[i].valid) begin
          if (exp_q.size() == 0) begin
            $display("Unexpected commit of pc %h on lane %0d", commit[i].pc, i);
            order_errors++;
          end else begin
            e = exp_q.pop_front();
            check_word($sformatf("commit %0d pc", commits_seen), e.pc, commit[i].pc);
            check_reg($sformatf("commit %0d rd", commits_seen), e.rd, commit[i].arch_rd);
            check_word($sformatf("commit %0d data", commits_seen), e.data, commit[i].data);
            check_phys($sformatf("commit %0d old_phys_rd", commits_seen), e.old_rd,
                       commit[i].old_phys_rd);
            commits_seen++;
          end
        end
      end
    end
  end

  initial begin : main
    clk          = 1'b0;
    rst          = 1'b1;
    instruction  = '0;
    instr_valid  = '0;
    value_errors = 0;
    order_errors = 0;
    commits_seen = 0;
    lfsr_state   = 32'h43ea;
    build_program();
    build_expected();
    total_expected = exp_q.size();

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    check_word("pc after reset", RESET_PC, pc);
    // Too early for anything to reach commit
    repeat (4) begin
      @(negedge clk);
      if (commit[0].valid || commit[1].valid) begin
        $display("Commit lane went valid before any instruction could reach it");
        order_errors++;
      end
    end

    while (commits_seen < total_expected) begin
      @(posedge clk);
    end
    // Extra commits would show up here
    repeat (20) @(posedge clk);

    print_summary();
    if (value_errors == 0 && order_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: only %0d of %0d expected commits arrived",
             commits_seen, total_expected);
    print_summary();
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+dv
design/isa_pkg.sv
design/core_pkg.sv
design/decode_stage.sv
design/free_list.sv
design/rename_stage.sv
design/reorder_buffer.sv
design/execute_stage.sv
design/rename_core.sv
dv/core_tb.sv
